/* verilog/mem_app_pkg.sv */
package mem_app_pkg;

  // Width of the byte address field on the controller app port
  localparam int APP_ADDR_BITS = 27;

  // Bytes per burst is 8, so the byte address is the burst index << 3
  localparam int BURST_SHIFT = 3;

  // Controller command encoding
  typedef enum logic [2:0] {
    APP_CMD_WRITE = 3'b000,
    APP_CMD_READ  = 3'b001
  } app_cmd_e;

  // One request on the app interface, qualified by app_en
  typedef struct packed {
    app_cmd_e                 cmd;
    logic [APP_ADDR_BITS-1:0] addr;
  } app_req_t;

endpackage

/* verilog/host_msg_pkg.sv */
package host_msg_pkg;

  typedef enum logic [3:0] {
    OP_SET_START  = 4'h1,
    OP_SET_END    = 4'h2,
    OP_SET_PASSES = 4'h3,
    OP_GO         = 4'h4,
    OP_GET_STATUS = 4'h5,
    OP_STATUS     = 4'h8  // Reply only
  } host_op_e;

  // Host to DUT view of the word
  typedef struct packed {
    host_op_e    op;
    logic [3:0]  rsvd;
    logic [23:0] value;
  } host_cmd_t;

  // DUT to host view of the same word
  typedef struct packed {
    host_op_e    op;
    logic [7:0]  rsvd;
    logic        busy;
    logic        done;
    logic        error;
    logic        heartbeat;
    logic [15:0] passes_done;
  } host_status_t;

  typedef union packed {
    host_cmd_t    cmd;
    host_status_t status;
  } host_msg_u;

  typedef struct packed {
    logic [23:0] start_burst;
    logic [23:0] end_burst;
    logic [15:0] passes;
    logic        go;
  } test_cfg_t;

  typedef struct packed {
    logic        busy;
    logic        done;
    logic        error;
    logic        heartbeat;
    logic [15:0] passes_done;
  } test_stat_t;

endpackage

/* verilog/mem_test_regs.sv */
module mem_test_regs
  import host_msg_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  host_msg_u  cmd,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  output host_msg_u  rsp,
  output logic       rsp_valid,
  input  logic       rsp_ready,
  output test_cfg_t  cfg,
  input  test_stat_t stat
);

  logic [23:0]  start_q;
  logic [23:0]  end_q;
  logic [15:0]  passes_q;
  logic         cmd_fire;
  logic         is_get_status;
  logic         cfg_wr;
  logic         go_fire;
  host_status_t status_word;

  assign is_get_status = (cmd.cmd.op == OP_GET_STATUS);

  // Reply must drain first; only get_status gets through during a run
  assign cmd_ready = !rsp_valid && (!stat.busy || is_get_status);
  assign cmd_fire  = cmd_valid && cmd_ready;

  // Anything but get_status is dropped while the generator is busy
  assign cfg_wr  = cmd_fire && !stat.busy;
  assign go_fire = cfg_wr && (cmd.cmd.op == OP_GO);

  assign cfg = '{
    start_burst: start_q,
    end_burst:   end_q,
    passes:      passes_q,
    go:          go_fire
  };

  always_comb begin
    status_word             = '0;
    status_word.op          = OP_STATUS;
    status_word.busy        = stat.busy;
    status_word.done        = stat.done;
    status_word.error       = stat.error;
    status_word.heartbeat   = stat.heartbeat;
    status_word.passes_done = stat.passes_done;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      start_q   <= '0;
      end_q     <= '0;
      passes_q  <= 16'd1;
      rsp_valid <= 1'b0;
    end else begin
      if (rsp_valid && rsp_ready) begin
        rsp_valid <= 1'b0;
      end
      if (cmd_fire && is_get_status) begin
        rsp_valid <= 1'b1;
      end
      if (cfg_wr) begin
        case (cmd.cmd.op)
          OP_SET_START:  start_q  <= cmd.cmd.value;
          OP_SET_END:    end_q    <= cmd.cmd.value;
          OP_SET_PASSES: passes_q <= cmd.cmd.value[15:0];
          default: ;
        endcase
      end
    end
  end

  // Status is sampled at acceptance and held until taken
  always_ff @(posedge clk) begin
    if (cmd_fire && is_get_status) begin
      rsp.status <= status_word;
    end
  end

endmodule

/* verilog/mem_traffic_gen.sv */
module mem_traffic_gen
  import mem_app_pkg::*;
  import host_msg_pkg::*;
#(
  parameter int ADDR_WIDTH     = 27,
  parameter int APP_DATA_WIDTH = 64
) (
  input  logic                      clk,
  input  logic                      reset,
  input  test_cfg_t                 cfg,
  output test_stat_t                stat,
  output app_req_t                  app_req,
  output logic                      app_en,
  input  logic                      app_rdy,
  output logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  input  logic                      app_wdf_rdy,
  input  logic                      app_rd_data_valid,
  input  logic [APP_DATA_WIDTH-1:0] app_rd_data
);

  localparam logic [4:0] MAX_INFLIGHT = 5'd16;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ,
    ST_DRAIN,
    ST_DONE
  } state_e;

  state_e                  state;
  logic [23:0]             burst;
  logic [ADDR_WIDTH-1:0]   byte_addr;
  logic [31:0]             wr_pat;     // Word on the write data bus
  logic [31:0]             pass_base;  // First word of the current pass
  logic [31:0]             exp_pat;
  logic [15:0]             pass_cnt;
  logic                    heartbeat;
  logic                    error;
  logic [4:0]              inflight;
  logic [4:0]              inflight_next;
  logic                    busy;
  logic                    start;
  logic                    last_burst;
  logic                    en_hold;
  logic                    wren_hold;
  logic                    rd_issue;
  logic                    rd_start;
  logic                    mismatch;

  assign busy       = (state == ST_WRITE) || (state == ST_READ) || (state == ST_DRAIN);
  assign start      = cfg.go && !busy;
  assign last_burst = (burst == cfg.end_burst);

  assign byte_addr    = ADDR_WIDTH'({burst, 3'b000});
  assign app_req.cmd  = (state == ST_WRITE) ? APP_CMD_WRITE : APP_CMD_READ;
  assign app_req.addr = APP_ADDR_BITS'(byte_addr);
  assign app_wdf_data = APP_DATA_WIDTH'(wr_pat);  // Upper bits zero
  assign app_wdf_end  = app_wdf_wren;             // One beat per burst

  // Write request and data each stay up until their own handshake
  assign en_hold   = app_en && !app_rdy;
  assign wren_hold = app_wdf_wren && !app_wdf_rdy;
  assign rd_start  = (state == ST_WRITE) && !en_hold && !wren_hold && last_burst;

  assign rd_issue      = (state == ST_READ) && app_en && app_rdy;
  assign inflight_next = inflight + 5'(rd_issue) - 5'(app_rd_data_valid);

  assign mismatch = app_rd_data_valid && (app_rd_data != APP_DATA_WIDTH'(exp_pat));

  assign stat = '{
    busy:        busy,
    done:        (state == ST_DONE),
    error:       error,
    heartbeat:   heartbeat,
    passes_done: pass_cnt
  };

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_IDLE;
      app_en       <= 1'b0;
      app_wdf_wren <= 1'b0;
      burst        <= '0;
      wr_pat       <= 32'd1;
      pass_base    <= 32'd1;
      pass_cnt     <= '0;
      heartbeat    <= 1'b0;
    end else begin
      case (state)
        ST_IDLE, ST_DONE: if (start) begin
          state        <= ST_WRITE;
          burst        <= cfg.start_burst;
          wr_pat       <= 32'd1;  // Counter restarts on each go
          pass_base    <= 32'd1;
          pass_cnt     <= '0;
          heartbeat    <= 1'b0;
          app_en       <= 1'b1;
          app_wdf_wren <= 1'b1;
        end
        ST_WRITE: begin
          if (!en_hold && !wren_hold) begin
            wr_pat <= wr_pat + 32'd1;
            app_en <= 1'b1;
            if (last_burst) begin
              state        <= ST_READ;
              burst        <= cfg.start_burst;
              app_wdf_wren <= 1'b0;
            end else begin
              burst        <= burst + 24'd1;
              app_wdf_wren <= 1'b1;
            end
          end else begin
            app_en       <= en_hold;
            app_wdf_wren <= wren_hold;
          end
        end
        ST_READ: begin
          if (mismatch) begin
            app_en <= 1'b0;  // Stop issuing, drain what is out
            state  <= ST_DRAIN;
          end else if (rd_issue) begin
            if (last_burst) begin
              app_en <= 1'b0;
              state  <= ST_DRAIN;
            end else begin
              burst  <= burst + 24'd1;
              app_en <= (inflight_next < MAX_INFLIGHT);
            end
          end else if (!app_en && inflight < MAX_INFLIGHT) begin
            app_en <= 1'b1;
          end
        end
        ST_DRAIN: if (inflight_next == 5'd0) begin
          if (error || mismatch) begin
            state <= ST_DONE;
          end else begin
            pass_cnt  <= pass_cnt + 16'd1;
            heartbeat <= !heartbeat;
            if (pass_cnt + 16'd1 >= cfg.passes) begin
              state <= ST_DONE;
            end else begin
              state        <= ST_WRITE;
              burst        <= cfg.start_burst;
              pass_base    <= wr_pat;
              app_en       <= 1'b1;
              app_wdf_wren <= 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      inflight <= '0;
    end else begin
      inflight <= inflight_next;
    end
  end

  // Compare path runs on every returned beat, whatever the FSM does
  always_ff @(posedge clk) begin
    if (reset) begin
      error <= 1'b0;
    end else if (start) begin
      error <= 1'b0;
    end else if (mismatch) begin
      error <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_start) begin
      exp_pat <= pass_base;
    end else if (app_rd_data_valid) begin
      exp_pat <= exp_pat + 32'd1;
    end
  end

endmodule

/* verilog/mem_test_top.sv */
module mem_test_top
  import mem_app_pkg::*;
  import host_msg_pkg::*;
#(
  parameter int ADDR_WIDTH     = 27,
  parameter int APP_DATA_WIDTH = 64
) (
  input  logic                      clk,
  input  logic                      reset,
  // Host command and status channels
  input  host_msg_u                 cmd,
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  output host_msg_u                 rsp,
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  // Controller app interface
  output app_req_t                  app_req,
  output logic                      app_en,
  input  logic                      app_rdy,
  output logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  input  logic                      app_wdf_rdy,
  input  logic                      app_rd_data_valid,
  input  logic [APP_DATA_WIDTH-1:0] app_rd_data
);

  test_cfg_t  cfg;
  test_stat_t stat;

  mem_test_regs regs (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .cfg       (cfg),
    .stat      (stat)
  );

  mem_traffic_gen #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .APP_DATA_WIDTH (APP_DATA_WIDTH)
  ) gen (
    .clk               (clk),
    .reset             (reset),
    .cfg               (cfg),
    .stat              (stat),
    .app_req           (app_req),
    .app_en            (app_en),
    .app_rdy           (app_rdy),
    .app_wdf_data      (app_wdf_data),
    .app_wdf_wren      (app_wdf_wren),
    .app_wdf_end       (app_wdf_end),
    .app_wdf_rdy       (app_wdf_rdy),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data       (app_rd_data)
  );

endmodule

/* tb/app_mem_model.sv */
module app_mem_model
  import mem_app_pkg::*;
#(
  parameter int APP_DATA_WIDTH = 64,
  parameter int DEPTH          = 64
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stall_en,
  input  app_req_t                  app_req,
  input  logic                      app_en,
  output logic                      app_rdy,
  input  logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  input  logic                      app_wdf_wren,
  output logic                      app_wdf_rdy,
  output logic                      app_rd_data_valid,
  output logic [APP_DATA_WIDTH-1:0] app_rd_data
);

  logic [APP_DATA_WIDTH-1:0] mem [int];
  int                        wr_addr_q[$];
  logic [APP_DATA_WIDTH-1:0] wr_data_q[$];
  int                        rd_addr_q[$];
  longint                    rd_due_q[$];
  longint                    now = 0;
  longint                    last_due = 0;
  logic [31:0]               lfsr = 32'hd7db_05d2;

  // Taps 32, 22, 2, 1
  function automatic logic random_bit();
    random_bit = lfsr[31];
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
  endfunction

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = APP_DATA_WIDTH'(64'hbad0_0000_0000_0000 + 64'(i) * 64'h0001_0001);
    end
    app_rdy           = 1'b1;
    app_wdf_rdy       = 1'b1;
    app_rd_data_valid = 1'b0;
    app_rd_data       = '0;
  end

  // Corrupts one stored word once the read phase begins
  task inject_fault(input int burst);
    do @(posedge clk); while (!(app_en && app_rdy && app_req.cmd == APP_CMD_READ));
    mem[burst][0] = ~mem[burst][0];
  endtask

  always @(posedge clk) begin : step
    logic [2:0] lat_bits;
    longint     due;
    now++;
    if (reset) begin
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
      rd_due_q.delete();
    end else begin
      if (app_en && app_rdy) begin
        if (app_req.cmd == APP_CMD_WRITE) begin
          wr_addr_q.push_back(int'(app_req.addr >> BURST_SHIFT));
        end else begin
          lat_bits = {random_bit(), random_bit(), random_bit()};
          due = now + 2 + longint'(lat_bits);
          if (due <= last_due) due = last_due + 1;  // Keep returns in order
          last_due = due;
          rd_addr_q.push_back(int'(app_req.addr >> BURST_SHIFT));
          rd_due_q.push_back(due);
        end
      end
      if (app_wdf_wren && app_wdf_rdy) wr_data_q.push_back(app_wdf_data);
      while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
        mem[wr_addr_q.pop_front()] = wr_data_q.pop_front();
      end
    end
    #1;
    app_rd_data_valid = 1'b0;
    if (!reset && rd_due_q.size() > 0 && rd_due_q[0] <= now) begin
      app_rd_data_valid = 1'b1;
      app_rd_data       = mem[rd_addr_q.pop_front()];
      void'(rd_due_q.pop_front());
    end
    app_rdy     = stall_en ? (random_bit() | random_bit()) : 1'b1;
    app_wdf_rdy = stall_en ? (random_bit() | random_bit()) : 1'b1;
  end

endmodule

/* tb/mem_test_asserts.sv */
module mem_test_asserts
  import mem_app_pkg::*;
  import host_msg_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input app_req_t   app_req,
  input logic       app_en,
  input logic       app_rdy,
  input host_msg_u  cmd,
  input logic       cmd_valid,
  input logic       cmd_ready,
  input host_msg_u  rsp,
  input logic       rsp_valid,
  input logic       rsp_ready,
  input test_stat_t stat
);

  req_held: assert property (@(posedge clk) disable iff (reset)
    app_en && !app_rdy |=> $stable(app_req))
    else $error("app_req changed while stalled");

  status_reply: assert property (@(posedge clk) disable iff (reset)
    cmd_valid && cmd_ready && cmd.cmd.op == OP_GET_STATUS
      |=> rsp_valid && rsp.status.op == OP_STATUS)
    else $error("no status reply the cycle after get_status");

  rsp_held: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("reply changed before it was taken");

  quiet_done: assert property (@(posedge clk) disable iff (reset)
    stat.done |-> !app_en)
    else $error("app_en high while done");

endmodule

bind mem_test_top mem_test_asserts asserts_i (
  .clk       (clk),
  .reset     (reset),
  .app_req   (app_req),
  .app_en    (app_en),
  .app_rdy   (app_rdy),
  .cmd       (cmd),
  .cmd_valid (cmd_valid),
  .cmd_ready (cmd_ready),
  .rsp       (rsp),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .stat      (stat)
);

/* tb/tb_mem_test.sv */
module tb_mem_test
  import mem_app_pkg::*;
  import host_msg_pkg::*;
;

  localparam int TIMEOUT = 20000;  // 32 bursts x 3 passes x worst latency, with margin

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  host_msg_u   cmd;
  logic        cmd_valid;
  logic        cmd_ready;
  logic        rsp_valid;
  logic        rsp_ready;
  logic        stall_en;
  host_msg_u   rsp;
  app_req_t    app_req;
  logic        app_en;
  logic        app_rdy;
  logic        app_wdf_wren;
  logic        app_wdf_end;
  logic        app_wdf_rdy;
  logic        app_rd_data_valid;
  logic [63:0] app_wdf_data;
  logic [63:0] app_rd_data;
  int          errors = 0;
  int          cycles = 0;

  mem_test_top uut (.*);
  app_mem_model model (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, the DUT never finished", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // Each burst is a single data beat
  always @(negedge clk) begin
    if (!reset && app_wdf_end !== app_wdf_wren) begin
      $display("Error: wdf_end expected %b actual %b", app_wdf_wren, app_wdf_end);
      errors++;
    end
  end

  // Holds the current command until the edge that takes it
  task wait_accept();
    logic ready;
    do begin
      @(negedge clk);
      ready = cmd_ready;
      @(posedge clk);
      #1;
    end while (!ready);
    cmd_valid = 1'b0;
  endtask

  task host_send(input host_op_e op, input logic [23:0] value);
    cmd.cmd   = '{op: op, rsvd: 4'h0, value: value};
    cmd_valid = 1'b1;
    wait_accept();
  endtask

  task get_status(output logic [19:0] bits);
    host_send(OP_GET_STATUS, 24'd0);
    do @(negedge clk); while (!rsp_valid);
    bits = {rsp.status.busy, rsp.status.done, rsp.status.error,
            rsp.status.heartbeat, rsp.status.passes_done};
    @(posedge clk);
    #1;
  endtask

  task wait_done();
    do @(negedge clk); while (!uut.gen.stat.done);
    @(posedge clk);
    #1;
  endtask

  task start_run(input int first, input int last, input int passes);
    host_send(OP_SET_START, 24'(first));
    host_send(OP_SET_END, 24'(last));
    host_send(OP_SET_PASSES, 24'(passes));
    host_send(OP_GO, 24'd0);
  endtask

  task check_status(input string name, input logic [19:0] exp);
    logic [19:0] st;
    get_status(st);
    if (st !== exp) begin
      $display("Error: %s status expected %h actual %h", name, exp, st);
      errors++;
    end
  endtask

  task check_mem(input string name, input int first, input int last, input int word);
    for (int b = first; b <= last; b++) begin
      if (model.mem[b] !== 64'(word + b - first)) begin
        $display("Error: %s burst %0d expected %h actual %h", name, b,
                 64'(word + b - first), model.mem[b]);
        errors++;
      end
    end
  endtask

  task reset_defaults();
    @(negedge clk);
    if (cmd_ready !== 1'b1) begin
      $display("Error: reset_defaults cmd_ready expected 1 actual %b", cmd_ready);
      errors++;
    end
    @(posedge clk);
    #1;
    check_status("reset_defaults", 20'h0);
  endtask

  task single_pass();
    start_run(0, 15, 1);
    wait_done();
    check_status("single_pass", {4'b0101, 16'd1});
    check_mem("single_pass", 0, 15, 1);
  endtask

  task multi_pass_stalls();
    stall_en = 1'b1;
    start_run(4, 35, 3);
    wait_done();
    stall_en = 1'b0;
    check_status("multi_pass", {4'b0101, 16'd3});  // Heartbeat is 3 mod 2
    check_mem("multi_pass", 4, 35, 2 * 32 + 1);
  endtask

  task fault_detect();
    start_run(0, 15, 1);
    model.inject_fault(7);
    wait_done();
    check_status("fault_detect", {4'b0110, 16'd0});
    repeat (20) begin
      @(negedge clk);
      if (app_en) begin
        $display("Error: fault_detect app_en expected 0 actual 1");
        errors++;
      end
    end
  endtask

  task status_backpressure();
    host_msg_u held;
    host_send(OP_SET_START, 24'd0);
    host_send(OP_SET_END, 24'd3);
    rsp_ready = 1'b0;
    host_send(OP_GET_STATUS, 24'd0);
    held          = rsp;
    cmd.cmd       = '{op: OP_SET_START, rsvd: 4'h0, value: 24'd2};
    cmd_valid     = 1'b1;
    repeat (10) begin
      @(negedge clk);
      if (!rsp_valid || rsp !== held || cmd_ready) begin
        $display("Error: status_backpressure hold expected %h/1/0 actual %h/%b/%b",
                 held, rsp, rsp_valid, cmd_ready);
        errors++;
      end
    end
    @(posedge clk);
    #1;
    rsp_ready = 1'b1;
    wait_accept();
    host_send(OP_GO, 24'd0);
    wait_done();
    check_mem("status_backpressure", 2, 3, 1);
  endtask

  task busy_reject();
    start_run(20, 23, 1);
    cmd.cmd   = '{op: OP_SET_END, rsvd: 4'h0, value: 24'd30};
    cmd_valid = 1'b1;
    repeat (3) begin
      @(negedge clk);
      if (cmd_ready) begin
        $display("Error: busy_reject cmd_ready expected 0 actual 1");
        errors++;
      end
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    wait_done();
    check_mem("busy_reject", 20, 23, 1);
    check_mem("busy_reject", 24, 24, 2 * 32 + 1 + 20);  // Left from the multi-pass run
  endtask

  initial begin
    cmd       = '0;
    cmd_valid = 1'b0;
    rsp_ready = 1'b1;
    stall_en  = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_defaults();
    single_pass();
    multi_pass_stalls();
    fault_detect();
    status_backpressure();
    busy_reject();
    $display("Finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tb.f */
verilog/mem_app_pkg.sv
verilog/host_msg_pkg.sv
verilog/mem_test_regs.sv
verilog/mem_traffic_gen.sv
verilog/mem_test_top.sv
tb/app_mem_model.sv
tb/mem_test_asserts.sv
tb/tb_mem_test.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory soak tester testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mem_test -o tb_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error"
  cat sim.log
  exit 1
fi

cat sim.log
if grep -q "^Test passed$" sim.log; then
  exit 0
fi
exit 1
